//--- rtl/elevPkg.sv
package elevPkg;

	localparam int NumFloors = 5;

	typedef logic [2:0] floorT;  // Only 0 to 4 are used

	typedef enum logic
	{
		DirUp = 1'b0,
		DirDown = 1'b1
	} dirT;

	// Hall payload is {floor, dir} with the direction in bit 0
	typedef logic [3:0] hallCallT;

	typedef floorT carCallT;

	// Clock cycles per step
	localparam int StepCycles = 250;

	typedef logic [7:0] stepCountT;

	// Segments are active low, ordered {a,b,c,d,e,f,g}
	localparam logic [6:0] DigitSegs [NumFloors] = '{
		7'b0000001,  // 0
		7'b1001111,  // 1
		7'b0010010,  // 2
		7'b0000110,  // 3
		7'b1001100   // 4
	};

	localparam logic [6:0] GlyphIdle = 7'b1111110;  // Dash
	localparam logic [6:0] GlyphUp = 7'b1000001;    // U
	localparam logic [6:0] GlyphDown = 7'b1000010;  // d

endpackage

//--- rtl/callHold.sv
`timescale 1ns/100ps

module callHold #(
	parameter type payloadT = logic [2:0]
) (
	input logic clk_50hz,
	input logic rst,
	input logic strobe,
	input payloadT payload,
	input logic take,
	output logic valid,
	output payloadT held
);

	// New call beats a take in the same cycle
	always_ff @(posedge clk_50hz)
	begin
		if (!rst)
			valid <= 1'b0;
		else if (strobe)
			valid <= 1'b1;
		else if (take)
			valid <= 1'b0;
	end

	always_ff @(posedge clk_50hz)
	begin
		if (strobe)
			held <= payload;
	end

	// A press always carries a known call
	payloadKnown: assert property (
		@(posedge clk_50hz) disable iff (!rst)
		strobe |-> !$isunknown(payload)
	);

endmodule

//--- rtl/callCapture.sv
`timescale 1ns/100ps

module callCapture (
	input logic clk_50hz,
	input logic rst,
	input logic [elevPkg::NumFloors-1:0] hallButtons,
	input logic [elevPkg::NumFloors-2:1] hallDirs,  // Middle floors only
	input logic [elevPkg::NumFloors-1:0] carButtons,
	input logic take,
	output logic hallValid,
	output elevPkg::hallCallT hallCall,
	output logic carValid,
	output elevPkg::carCallT carCall
);

	logic [elevPkg::NumFloors-1:0] dirByFloor;
	logic [elevPkg::NumFloors-1:0] carPrev;
	logic [elevPkg::NumFloors-1:0] carEdges;
	logic hallHit;
	logic carHit;
	elevPkg::hallCallT hallEnc;
	elevPkg::carCallT carEnc;
	logic hallStrobe;
	logic carStrobe;
	elevPkg::hallCallT hallPayload;
	elevPkg::carCallT carPayload;

	// Bottom floor can only go up, top floor only down
	assign dirByFloor = {1'(elevPkg::DirDown), hallDirs, 1'(elevPkg::DirUp)};
	assign carEdges = carButtons & ~carPrev;

	// Lowest floor wins
	always_comb
	begin
		hallHit = 1'b0;
		carHit = 1'b0;
		hallEnc = '0;
		carEnc = '0;
		for (int i = elevPkg::NumFloors - 1; i >= 0; i--)
		begin
			if (hallButtons[i])
			begin
				hallHit = 1'b1;
				hallEnc = {elevPkg::floorT'(i), dirByFloor[i]};
			end
			if (carEdges[i])
			begin
				carHit = 1'b1;
				carEnc = elevPkg::carCallT'(i);
			end
		end
	end

	always_ff @(posedge clk_50hz)
	begin
		if (!rst)
		begin
			carPrev <= '0;
			hallStrobe <= 1'b0;
			carStrobe <= 1'b0;
		end
		else
		begin
			carPrev <= carButtons;
			hallStrobe <= hallHit;
			carStrobe <= carHit;
		end
	end

	always_ff @(posedge clk_50hz)
	begin
		hallPayload <= hallEnc;
		carPayload <= carEnc;
	end

	callHold #(.payloadT(elevPkg::hallCallT)) u_hallHold (
		.clk_50hz(clk_50hz), .rst(rst), .strobe(hallStrobe), .payload(hallPayload),
		.take(take), .valid(hallValid), .held(hallCall)
	);

	callHold #(.payloadT(elevPkg::carCallT)) u_carHold (
		.clk_50hz(clk_50hz), .rst(rst), .strobe(carStrobe), .payload(carPayload),
		.take(take), .valid(carValid), .held(carCall)
	);

endmodule

//--- rtl/carController.sv
`timescale 1ns/100ps

module carController (
	input logic clk_50hz,
	input logic rst,
	input logic hallValid,
	input elevPkg::hallCallT hallCall,
	input logic carValid,
	input elevPkg::carCallT carCall,
	output logic take,
	output elevPkg::floorT curFloor,
	output elevPkg::dirT travelDir,
	output logic moving,
	output logic doorOpen,
	output logic [elevPkg::NumFloors-1:0] hallLamps,
	output logic [elevPkg::NumFloors-1:0] carLamps
);

	elevPkg::stepCountT stepCount;
	logic tick;
	elevPkg::floorT dest;
	elevPkg::floorT stopFloor;
	logic stopValid;

	logic callHit;
	elevPkg::floorT callFloor;
	logic dirOk;
	logic inPath;
	logic startCall;
	logic addStop;
	logic atDest;
	logic atStop;

	assign tick = (stepCount == elevPkg::stepCountT'(elevPkg::StepCycles - 1));
	assign take = tick;  // Calls are consumed every step, served or not

	// Hall call has priority over the car call
	always_comb
	begin
		callHit = hallValid || carValid;
		callFloor = hallValid ? hallCall[3:1] : carCall;
		dirOk = !hallValid || (elevPkg::dirT'(hallCall[0]) == travelDir);
		if (travelDir == elevPkg::DirUp)
			inPath = (callFloor > curFloor) && (callFloor < dest);
		else
			inPath = (callFloor < curFloor) && (callFloor > dest);
		startCall = tick && callHit && !moving && (callFloor != curFloor);
		addStop = tick && callHit && moving && inPath && dirOk;
		atDest = moving && (curFloor == dest);
		atStop = stopValid && (curFloor == stopFloor);
	end

	always_ff @(posedge clk_50hz)
	begin
		if (!rst)
			stepCount <= '0;
		else if (tick)
			stepCount <= '0;
		else
			stepCount <= stepCount + 1'b1;
	end

	always_ff @(posedge clk_50hz)
	begin
		if (!rst)
		begin
			curFloor <= '0;
			travelDir <= elevPkg::DirUp;
			moving <= 1'b0;
			doorOpen <= 1'b0;
			stopValid <= 1'b0;
			hallLamps <= '0;
			carLamps <= '0;
		end
		else if (tick)
		begin
			if (atDest)
			begin
				hallLamps[curFloor] <= 1'b0;
				carLamps[curFloor] <= 1'b0;
				doorOpen <= 1'b1;
				moving <= 1'b0;
			end
			else if (atStop)
			begin
				hallLamps[curFloor] <= 1'b0;
				carLamps[curFloor] <= 1'b0;
				doorOpen <= 1'b1;
				stopValid <= 1'b0;
			end
			else
			begin
				doorOpen <= 1'b0;
				if (moving)
				begin
					if (travelDir == elevPkg::DirUp)
						curFloor <= curFloor + 1'b1;
					else
						curFloor <= curFloor - 1'b1;
				end
			end

			// Lamp sets come last so a new call is not cleared
			if (startCall)
			begin
				moving <= 1'b1;
				travelDir <= (callFloor > curFloor) ? elevPkg::DirUp : elevPkg::DirDown;
			end
			if (addStop)
				stopValid <= 1'b1;
			if (startCall || addStop)
			begin
				if (hallValid)
					hallLamps[callFloor] <= 1'b1;
				else
					carLamps[callFloor] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_50hz)
	begin
		if (startCall)
			dest <= callFloor;
		if (addStop)
			stopFloor <= callFloor;
	end

	floorInRange: assert property (
		@(posedge clk_50hz) disable iff (!rst)
		curFloor < elevPkg::NumFloors
	);

	// Steps end at the destination and never overshoot it
	noOvershoot: assert property (
		@(posedge clk_50hz) disable iff (!rst)
		(tick && moving && !atDest && !atStop) |=>
			((travelDir == elevPkg::DirUp) ? (curFloor <= dest) : (curFloor >= dest))
	);

endmodule

//--- rtl/statusDisplay.sv
`timescale 1ns/100ps

module statusDisplay (
	input elevPkg::floorT curFloor,
	input elevPkg::dirT travelDir,
	input logic moving,
	input logic doorOpen,
	output logic [6:0] floorSegs,
	output logic [6:0] dirSegs,
	output logic busy
);

	// Floor digit
	always_comb
	begin
		if (curFloor < elevPkg::NumFloors)
			floorSegs = elevPkg::DigitSegs[curFloor];
		else
			floorSegs = 7'b1111111;  // Blank
	end

	// Direction glyph, dash while parked
	always_comb
	begin
		if (!moving)
			dirSegs = elevPkg::GlyphIdle;
		else if (travelDir == elevPkg::DirUp)
			dirSegs = elevPkg::GlyphUp;
		else
			dirSegs = elevPkg::GlyphDown;
	end

	assign busy = doorOpen;  // Door open for one step at a stop

endmodule

//--- rtl/elevatorTop.sv
`timescale 1ns/100ps

module elevatorTop (
	input logic clk_50hz,
	input logic rst,
	input logic [elevPkg::NumFloors-1:0] hallButtons,
	input logic [elevPkg::NumFloors-2:1] hallDirs,
	input logic [elevPkg::NumFloors-1:0] carButtons,
	output logic [elevPkg::NumFloors-1:0] hallLamps,
	output logic [elevPkg::NumFloors-1:0] carLamps,
	output logic busy,
	output logic [6:0] floorSegs,
	output logic [6:0] dirSegs
);

	logic hallValid;
	elevPkg::hallCallT hallCall;
	logic carValid;
	elevPkg::carCallT carCall;
	logic take;
	elevPkg::floorT curFloor;
	elevPkg::dirT travelDir;
	logic moving;
	logic doorOpen;

	callCapture u_capture (
		.clk_50hz(clk_50hz), .rst(rst),
		.hallButtons(hallButtons), .hallDirs(hallDirs), .carButtons(carButtons),
		.take(take),
		.hallValid(hallValid), .hallCall(hallCall),
		.carValid(carValid), .carCall(carCall)
	);

	carController u_ctrl (
		.clk_50hz(clk_50hz), .rst(rst),
		.hallValid(hallValid), .hallCall(hallCall),
		.carValid(carValid), .carCall(carCall),
		.take(take), .curFloor(curFloor), .travelDir(travelDir),
		.moving(moving), .doorOpen(doorOpen),
		.hallLamps(hallLamps), .carLamps(carLamps)
	);

	statusDisplay u_disp (
		.curFloor(curFloor), .travelDir(travelDir), .moving(moving), .doorOpen(doorOpen),
		.floorSegs(floorSegs), .dirSegs(dirSegs), .busy(busy)
	);

endmodule

//--- bench/elevatorTb.sv
`timescale 1ns/100ps

module elevatorTb;

	localparam int DirectedSteps = 42;
	localparam int RandomSteps = 60;
	localparam int TimeoutCycles = (DirectedSteps + RandomSteps + 4) * elevPkg::StepCycles;
	localparam logic [31:0] Seed = 32'hcb13_3085;
	localparam int PressAt = 100;  // Cycles into a step
	localparam int PressLength = 20;

	logic clk_50hz;
	logic rst;
	logic [elevPkg::NumFloors-1:0] hallButtons;
	logic [elevPkg::NumFloors-2:1] hallDirs;
	logic [elevPkg::NumFloors-1:0] carButtons;
	logic [elevPkg::NumFloors-1:0] hallLamps;
	logic [elevPkg::NumFloors-1:0] carLamps;
	logic busy;
	logic [6:0] floorSegs;
	logic [6:0] dirSegs;

	int cycleCount;
	int checkCount;
	int errorCount;
	logic [31:0] randState;
	logic [elevPkg::NumFloors-1:0] carLevel;  // Car buttons as last driven

	// Calls waiting for the next tick
	logic pendHall;
	int pendHallFloor;
	logic pendHallDir;
	logic pendCar;
	int pendCarFloor;

	// Reference model state
	int mFloor;
	elevPkg::dirT mDir;
	logic mMoving;
	logic mDoor;
	int mDest;
	int mStop;
	logic mStopValid;
	logic [elevPkg::NumFloors-1:0] mHallLamps;
	logic [elevPkg::NumFloors-1:0] mCarLamps;

	elevatorTop u_dut (
		.clk_50hz(clk_50hz), .rst(rst),
		.hallButtons(hallButtons), .hallDirs(hallDirs), .carButtons(carButtons),
		.hallLamps(hallLamps), .carLamps(carLamps), .busy(busy),
		.floorSegs(floorSegs), .dirSegs(dirSegs)
	);

	initial
	begin
		clk_50hz = 1'b0;
		forever #4 clk_50hz = ~clk_50hz;
	end

	always @(posedge clk_50hz)
	begin
		if (!rst)
			cycleCount <= 0;
		else
			cycleCount <= cycleCount + 1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// One step of the car rules, arrival first, then the call
	function automatic void refStep(input logic hallHit, input int hallFloor, input logic hallDir,
		input logic carHit, input int carFloor);
		int oldFloor;
		logic oldMoving;
		elevPkg::dirT oldDir;
		int callFloor;
		logic inPath;
		logic accepted;
		oldFloor = mFloor;
		oldMoving = mMoving;
		oldDir = mDir;
		accepted = 1'b0;
		callFloor = hallHit ? hallFloor : carFloor;
		if (oldDir == elevPkg::DirUp)
			inPath = (callFloor > oldFloor) && (callFloor < mDest);
		else
			inPath = (callFloor < oldFloor) && (callFloor > mDest);
		if (hallHit && (hallDir != oldDir))
			inPath = 1'b0;  // Wrong way for a stop
		if (oldMoving && (oldFloor == mDest))
		begin
			mHallLamps[oldFloor] = 1'b0;
			mCarLamps[oldFloor] = 1'b0;
			mDoor = 1'b1;
			mMoving = 1'b0;
		end
		else if (mStopValid && (oldFloor == mStop))
		begin
			mHallLamps[oldFloor] = 1'b0;
			mCarLamps[oldFloor] = 1'b0;
			mDoor = 1'b1;
			mStopValid = 1'b0;
		end
		else
		begin
			mDoor = 1'b0;
			if (oldMoving)
				mFloor = (oldDir == elevPkg::DirUp) ? oldFloor + 1 : oldFloor - 1;
		end
		if ((hallHit || carHit) && !oldMoving && (callFloor != oldFloor))
		begin
			mDest = callFloor;
			mMoving = 1'b1;
			mDir = (callFloor > oldFloor) ? elevPkg::DirUp : elevPkg::DirDown;
			accepted = 1'b1;
		end
		else if ((hallHit || carHit) && oldMoving && inPath)
		begin
			mStop = callFloor;
			mStopValid = 1'b1;
			accepted = 1'b1;
		end
		if (accepted && hallHit)
			mHallLamps[callFloor] = 1'b1;
		else if (accepted)
			mCarLamps[callFloor] = 1'b1;
	endfunction

	// Lit segments in order a to g for each digit
	function automatic logic [6:0] digitPattern(input int floorNum);
		logic [6:0] lit;
		case (floorNum)
			0: lit = 7'b1111110;
			1: lit = 7'b0110000;
			2: lit = 7'b1101101;
			3: lit = 7'b1111001;
			4: lit = 7'b0110011;
			default: lit = 7'b0000000;
		endcase
		return ~lit;  // Outputs are active low
	endfunction

	function automatic logic [6:0] expectedGlyph();
		if (!mMoving)
			return ~7'b0000001;  // Dash
		else if (mDir == elevPkg::DirUp)
			return ~7'b0111110;  // U
		else
			return ~7'b0111101;  // d
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// Press mid-step, release before the tick, end on the tick edge
	task automatic runStep(input logic [4:0] hall, input logic [3:1] dirs, input logic [4:0] car,
		input logic holdCar);
		logic [4:0] edges;
		edges = car & ~carLevel;
		repeat (PressAt) @(posedge clk_50hz);
		hallButtons <= hall;
		hallDirs <= dirs;
		carButtons <= car;
		carLevel = car;
		for (int i = elevPkg::NumFloors - 1; i >= 0; i--)
		begin
			if (hall[i])
			begin
				pendHall = 1'b1;
				pendHallFloor = i;
			end
			if (edges[i])
			begin
				pendCar = 1'b1;
				pendCarFloor = i;
			end
		end
		if (pendHallFloor == 0)
			pendHallDir = elevPkg::DirUp;
		else if (pendHallFloor == elevPkg::NumFloors - 1)
			pendHallDir = elevPkg::DirDown;
		else
			pendHallDir = dirs[pendHallFloor];
		repeat (PressLength) @(posedge clk_50hz);
		hallButtons <= '0;
		if (!holdCar)
		begin
			carButtons <= '0;
			carLevel = '0;
		end
		repeat (elevPkg::StepCycles - PressAt - PressLength) @(posedge clk_50hz);
	endtask

	task automatic idleSteps(input int n);
		repeat (n) runStep('0, '0, '0, 1'b0);
	endtask

	// Model and DUT compared once per step, right after the tick edge
	always @(negedge clk_50hz)
	begin
		if (rst && (cycleCount > 0) && ((cycleCount % elevPkg::StepCycles) == 0))
		begin
			refStep(pendHall, pendHallFloor, pendHallDir, pendCar, pendCarFloor);
			pendHall = 1'b0;
			pendCar = 1'b0;
			compareValue("hallLamps", hallLamps, mHallLamps);
			compareValue("carLamps", carLamps, mCarLamps);
			compareValue("busy", busy, mDoor);
			compareValue("floorSegs", floorSegs, digitPattern(mFloor));
			compareValue("dirSegs", dirSegs, expectedGlyph());
		end
	end

	initial
	begin
		wait (cycleCount >= TimeoutCycles);
		$display("timeout: test did not finish within %0d cycles", TimeoutCycles);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		rst = 1'b0;
		hallButtons = '0;
		hallDirs = '0;
		carButtons = '0;
		carLevel = '0;
		pendHall = 1'b0;
		pendHallFloor = 0;
		pendHallDir = 1'b0;
		pendCar = 1'b0;
		pendCarFloor = 0;
		mFloor = 0;
		mDir = elevPkg::DirUp;
		mMoving = 1'b0;
		mDoor = 1'b0;
		mDest = 0;
		mStop = 0;
		mStopValid = 1'b0;
		mHallLamps = '0;
		mCarLamps = '0;
		checkCount = 0;
		errorCount = 0;
		randState = Seed;
		repeat (2) @(posedge clk_50hz);
		rst <= 1'b1;

		idleSteps(3);  // Parked at 0
		runStep('0, '0, 5'b01000, 1'b0);
		idleSteps(5);

		// Back to 0, then up to 4 past a down call at 1 and an up stop at 2
		runStep('0, '0, 5'b00001, 1'b0);
		idleSteps(5);
		runStep('0, '0, 5'b10000, 1'b0);
		runStep(5'b00010, 3'b001, '0, 1'b0);
		runStep(5'b00100, 3'b000, '0, 1'b0);
		idleSteps(5);

		// Hall beats car, then a call to the floor the car is on
		runStep(5'b00010, 3'b001, 5'b00100, 1'b0);
		idleSteps(5);
		runStep('0, '0, 5'b00010, 1'b0);
		idleSteps(1);

		// Car 3 held while a hall call takes the car to 0
		runStep(5'b00001, '0, 5'b01000, 1'b1);
		repeat (3) runStep('0, '0, 5'b01000, 1'b1);
		runStep('0, '0, '0, 1'b0);
		runStep('0, '0, 5'b01000, 1'b0);  // Second press
		idleSteps(5);

		for (int n = 0; n < RandomSteps; n++)
		begin
			randState = xorshift(randState);
			runStep((randState[2:0] == 3'd0) ? randState[12:8] : 5'b00000, randState[20:18],
				(randState[5:3] < 3'd2) ? randState[17:13] : 5'b00000, randState[6]);
		end

		repeat (2) @(posedge clk_50hz);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if ((errorCount == 0) && (checkCount > 0))
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- flist.f
rtl/elevPkg.sv
rtl/callHold.sv
rtl/callCapture.sv
rtl/carController.sv
rtl/statusDisplay.sv
rtl/elevatorTop.sv
bench/elevatorTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = elevatorTb
FLIST     = flist.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSMSG   = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASSMSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
